// ==== logic/axi_sram_pkg.sv ====
// Shared widths, memory depth, AXI enums and address helpers for the AXI4 SRAM
`default_nettype none

package axi_sram_pkg;

  localparam int DATA_WIDTH = 64;
  localparam int STRB_WIDTH = DATA_WIDTH / 8;
  localparam int ADDR_WIDTH = 32;
  localparam int ID_WIDTH   = 4;
  localparam int MEM_WORDS  = 1024;
  localparam int WORD_AW    = 10;
  localparam int BYTE_OFS   = 3;

  typedef enum logic [1:0] {
    BURST_FIXED = 2'b00,
    BURST_INCR  = 2'b01,
    BURST_WRAP  = 2'b10
  } burst_e;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } resp_e;

  typedef enum logic {
    RD_IDLE,
    RD_BURST
  } rd_state_e;

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_DATA,
    WR_RESP
  } wr_state_e;

  // --------------------
  // Address rule helpers

  function automatic logic addr_in_range(input logic [ADDR_WIDTH-1:0] addr);
    return addr < ADDR_WIDTH'(MEM_WORDS << BYTE_OFS);
  endfunction

  function automatic logic [WORD_AW-1:0] word_index(input logic [ADDR_WIDTH-1:0] addr);
    return WORD_AW'(addr >> BYTE_OFS);
  endfunction

  // WRAP steps like INCR
  function automatic logic [ADDR_WIDTH-1:0] next_addr(input logic [ADDR_WIDTH-1:0] addr,
                                                      input burst_e burst);
    if (burst == BURST_FIXED) begin
      return addr;
    end
    return addr + ADDR_WIDTH'(STRB_WIDTH);
  endfunction

  function automatic resp_e addr_resp(input logic [ADDR_WIDTH-1:0] addr);
    if (addr_in_range(addr)) begin
      return RESP_OKAY;
    end
    return RESP_DECERR;
  endfunction

endpackage

`default_nettype wire

// ==== logic/sram_mem.sv ====
// Two-port SRAM word array with byte-strobed write port and registered read port
`timescale 1ns/10ps
`default_nettype none

module sram_mem (
  input  wire                                   i_aclk,

  // Write port
  input  wire                                   i_we,
  input  wire [axi_sram_pkg::WORD_AW-1:0]       i_waddr,
  input  wire [axi_sram_pkg::DATA_WIDTH-1:0]    i_wdata,
  input  wire [axi_sram_pkg::STRB_WIDTH-1:0]    i_wstrb,

  // Read port
  input  wire                                   i_re,
  input  wire [axi_sram_pkg::WORD_AW-1:0]       i_raddr,
  output logic [axi_sram_pkg::DATA_WIDTH-1:0]   o_rdata
);

  import axi_sram_pkg::*;

  logic [DATA_WIDTH-1:0] mem_q [MEM_WORDS];

  // --------------------
  // Byte-lane writes

  always_ff @(posedge i_aclk) begin
    if (i_we) begin
      for (int b = 0; b < STRB_WIDTH; b++) begin
        if (i_wstrb[b]) begin
          mem_q[i_waddr][b*8 +: 8] <= i_wdata[b*8 +: 8];
        end
      end
    end
  end

  // --------------------
  // Read register

  // Same-word read and write in one cycle sees the old word
  always_ff @(posedge i_aclk) begin
    if (i_re) begin
      o_rdata <= mem_q[i_raddr];
    end
  end

endmodule

`default_nettype wire

// ==== logic/axi_sram_rd_ctrl.sv ====
// AXI4 read controller with AR/R handshake, burst address and beat counting and array read request
`timescale 1ns/10ps
`default_nettype none

module axi_sram_rd_ctrl (
  input  wire                                   i_aclk,
  input  wire                                   i_rst_n,

  // AR channel
  input  wire [axi_sram_pkg::ID_WIDTH-1:0]      i_arid,
  input  wire [axi_sram_pkg::ADDR_WIDTH-1:0]    i_araddr,
  input  wire [7:0]                             i_arlen,
  input  axi_sram_pkg::burst_e                  i_arburst,
  input  wire                                   i_arvalid,
  output logic                                  o_arready,

  // R channel control only
  input  wire                                   i_rready,
  output logic [axi_sram_pkg::ID_WIDTH-1:0]     o_rid,
  output axi_sram_pkg::resp_e                   o_rresp,
  output logic                                  o_rlast,
  output logic                                  o_rvalid,

  // Array read port
  output logic                                  o_mem_re,
  output logic [axi_sram_pkg::WORD_AW-1:0]      o_mem_raddr
);

  import axi_sram_pkg::*;

  rd_state_e             state_q;
  logic                  arready_q;
  logic                  rvalid_q;
  logic                  rlast_q;
  logic [7:0]            beat_q;
  logic [7:0]            len_q;
  burst_e                burst_q;
  logic [ID_WIDTH-1:0]   rid_q;
  resp_e                 rresp_q;
  logic [ADDR_WIDTH-1:0] addr_q;
  logic [ADDR_WIDTH-1:0] addr_nxt;
  logic                  ar_fire;
  logic                  r_fire;

  assign ar_fire  = i_arvalid & arready_q;
  assign r_fire   = rvalid_q & i_rready;
  assign addr_nxt = next_addr(addr_q, burst_q);

  // --------------------
  // Array read request

  // Fetch first word on AR, next word on every non-final R beat
  assign o_mem_re    = ar_fire | (r_fire & ~rlast_q);
  assign o_mem_raddr = (state_q == RD_IDLE) ? word_index(i_araddr) : word_index(addr_nxt);

  // --------------------
  // FSM and beat counter

  always_ff @(posedge i_aclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state_q   <= RD_IDLE;
      arready_q <= 1'b0;
      rvalid_q  <= 1'b0;
      rlast_q   <= 1'b0;
      beat_q    <= 8'd0;
    end else begin
      case (state_q)
        RD_IDLE: begin
          arready_q <= ~ar_fire;
          if (ar_fire) begin
            state_q  <= RD_BURST;
            rvalid_q <= 1'b1;
            rlast_q  <= (i_arlen == 8'd0);
            beat_q   <= 8'd0;
          end
        end
        RD_BURST: begin
          if (r_fire) begin
            if (rlast_q) begin
              state_q   <= RD_IDLE;
              rvalid_q  <= 1'b0;
              rlast_q   <= 1'b0;
              arready_q <= 1'b1;
            end else begin
              beat_q  <= beat_q + 8'd1;
              rlast_q <= (beat_q + 8'd1 == len_q);
            end
          end
        end
        default: begin
          state_q <= RD_IDLE;
        end
      endcase
    end
  end

  // Burst attributes and running address
  always_ff @(posedge i_aclk) begin
    if (ar_fire) begin
      rid_q   <= i_arid;
      len_q   <= i_arlen;
      burst_q <= i_arburst;
      addr_q  <= i_araddr;
      rresp_q <= addr_resp(i_araddr);
    end else if (r_fire && !rlast_q) begin
      addr_q  <= addr_nxt;
      rresp_q <= addr_resp(addr_nxt);
    end
  end

  assign o_arready = arready_q;
  assign o_rvalid  = rvalid_q;
  assign o_rlast   = rlast_q;
  assign o_rid     = rid_q;
  assign o_rresp   = rresp_q;

endmodule

`default_nettype wire

// ==== logic/axi_sram_wr_ctrl.sv ====
// AXI4 write controller with AW/W/B handshake, burst stepping, beat count check and array writes
`timescale 1ns/10ps
`default_nettype none

module axi_sram_wr_ctrl (
  input  wire                                   i_aclk,
  input  wire                                   i_rst_n,

  // AW channel
  input  wire [axi_sram_pkg::ID_WIDTH-1:0]      i_awid,
  input  wire [axi_sram_pkg::ADDR_WIDTH-1:0]    i_awaddr,
  input  wire [7:0]                             i_awlen,
  input  axi_sram_pkg::burst_e                  i_awburst,
  input  wire                                   i_awvalid,
  output logic                                  o_awready,

  // W channel
  input  wire [axi_sram_pkg::DATA_WIDTH-1:0]    i_wdata,
  input  wire [axi_sram_pkg::STRB_WIDTH-1:0]    i_wstrb,
  input  wire                                   i_wlast,
  input  wire                                   i_wvalid,
  output logic                                  o_wready,

  // B channel
  output logic [axi_sram_pkg::ID_WIDTH-1:0]     o_bid,
  output axi_sram_pkg::resp_e                   o_bresp,
  output logic                                  o_bvalid,
  input  wire                                   i_bready,

  // Array write port
  output logic                                  o_mem_we,
  output logic [axi_sram_pkg::WORD_AW-1:0]      o_mem_waddr,
  output logic [axi_sram_pkg::DATA_WIDTH-1:0]   o_mem_wdata,
  output logic [axi_sram_pkg::STRB_WIDTH-1:0]   o_mem_wstrb
);

  import axi_sram_pkg::*;

  wr_state_e             state_q;
  logic                  awready_q;
  logic                  wready_q;
  logic                  bvalid_q;
  logic [7:0]            beat_q;
  logic [7:0]            len_q;
  burst_e                burst_q;
  logic [ID_WIDTH-1:0]   bid_q;
  logic [ADDR_WIDTH-1:0] addr_q;
  logic                  oor_q;
  logic                  mis_q;
  logic                  aw_fire;
  logic                  w_fire;
  logic                  b_fire;
  logic                  beat_final;
  logic                  beat_oor;
  logic                  beat_mis;

  assign aw_fire = i_awvalid & awready_q;
  assign w_fire  = i_wvalid & wready_q;
  assign b_fire  = bvalid_q & i_bready;

  // Current beat checks
  assign beat_final = (beat_q == len_q);
  assign beat_oor   = ~addr_in_range(addr_q);
  assign beat_mis   = (i_wlast != beat_final);

  // --------------------
  // Array write request

  assign o_mem_we    = w_fire & ~beat_oor;
  assign o_mem_waddr = word_index(addr_q);
  assign o_mem_wdata = i_wdata;
  assign o_mem_wstrb = i_wstrb;

  // --------------------
  // FSM, beat counter, sticky error flags

  always_ff @(posedge i_aclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state_q   <= WR_IDLE;
      awready_q <= 1'b0;
      wready_q  <= 1'b0;
      bvalid_q  <= 1'b0;
      beat_q    <= 8'd0;
      oor_q     <= 1'b0;
      mis_q     <= 1'b0;
    end else begin
      case (state_q)
        WR_IDLE: begin
          awready_q <= ~aw_fire;
          if (aw_fire) begin
            state_q  <= WR_DATA;
            wready_q <= 1'b1;
            beat_q   <= 8'd0;
            oor_q    <= 1'b0;
            mis_q    <= 1'b0;
          end
        end
        WR_DATA: begin
          if (w_fire) begin
            beat_q <= beat_q + 8'd1;
            oor_q  <= oor_q | beat_oor;
            mis_q  <= mis_q | beat_mis;
            // Burst length is set by awlen, not by wlast
            if (beat_final) begin
              state_q  <= WR_RESP;
              wready_q <= 1'b0;
              bvalid_q <= 1'b1;
            end
          end
        end
        WR_RESP: begin
          if (b_fire) begin
            state_q   <= WR_IDLE;
            bvalid_q  <= 1'b0;
            awready_q <= 1'b1;
          end
        end
        default: begin
          state_q <= WR_IDLE;
        end
      endcase
    end
  end

  // Burst attributes and running address
  always_ff @(posedge i_aclk) begin
    if (aw_fire) begin
      bid_q   <= i_awid;
      len_q   <= i_awlen;
      burst_q <= i_awburst;
      addr_q  <= i_awaddr;
    end else if (w_fire) begin
      addr_q <= next_addr(addr_q, burst_q);
    end
  end

  // DECERR beats SLVERR
  always_comb begin
    if (oor_q) begin
      o_bresp = RESP_DECERR;
    end else if (mis_q) begin
      o_bresp = RESP_SLVERR;
    end else begin
      o_bresp = RESP_OKAY;
    end
  end

  assign o_awready = awready_q;
  assign o_wready  = wready_q;
  assign o_bvalid  = bvalid_q;
  assign o_bid     = bid_q;

endmodule

`default_nettype wire

// ==== logic/axi_sram_top.sv ====
// AXI4 SRAM top level joining the read controller, write controller and word array
`timescale 1ns/10ps
`default_nettype none

module axi_sram_top (
  input  wire                                   i_aclk,
  input  wire                                   i_rst_n,

  // AW channel
  input  wire [axi_sram_pkg::ID_WIDTH-1:0]      i_awid,
  input  wire [axi_sram_pkg::ADDR_WIDTH-1:0]    i_awaddr,
  input  wire [7:0]                             i_awlen,
  input  wire [1:0]                             i_awburst,
  input  wire                                   i_awvalid,
  output logic                                  o_awready,

  // W channel
  input  wire [axi_sram_pkg::DATA_WIDTH-1:0]    i_wdata,
  input  wire [axi_sram_pkg::STRB_WIDTH-1:0]    i_wstrb,
  input  wire                                   i_wlast,
  input  wire                                   i_wvalid,
  output logic                                  o_wready,

  // B channel
  output logic [axi_sram_pkg::ID_WIDTH-1:0]     o_bid,
  output logic [1:0]                            o_bresp,
  output logic                                  o_bvalid,
  input  wire                                   i_bready,

  // AR channel
  input  wire [axi_sram_pkg::ID_WIDTH-1:0]      i_arid,
  input  wire [axi_sram_pkg::ADDR_WIDTH-1:0]    i_araddr,
  input  wire [7:0]                             i_arlen,
  input  wire [1:0]                             i_arburst,
  input  wire                                   i_arvalid,
  output logic                                  o_arready,

  // R channel
  output logic [axi_sram_pkg::ID_WIDTH-1:0]     o_rid,
  output logic [axi_sram_pkg::DATA_WIDTH-1:0]   o_rdata,
  output logic [1:0]                            o_rresp,
  output logic                                  o_rlast,
  output logic                                  o_rvalid,
  input  wire                                   i_rready
);

  import axi_sram_pkg::*;

  logic                  mem_we;
  logic [WORD_AW-1:0]    mem_waddr;
  logic [DATA_WIDTH-1:0] mem_wdata;
  logic [STRB_WIDTH-1:0] mem_wstrb;
  logic                  mem_re;
  logic [WORD_AW-1:0]    mem_raddr;

  // --------------------
  // Read side

  axi_sram_rd_ctrl rd_ctrl0 (
    .i_aclk      (i_aclk),
    .i_rst_n     (i_rst_n),
    .i_arid      (i_arid),
    .i_araddr    (i_araddr),
    .i_arlen     (i_arlen),
    .i_arburst   (burst_e'(i_arburst)),
    .i_arvalid   (i_arvalid),
    .o_arready   (o_arready),
    .i_rready    (i_rready),
    .o_rid       (o_rid),
    .o_rresp     (o_rresp),
    .o_rlast     (o_rlast),
    .o_rvalid    (o_rvalid),
    .o_mem_re    (mem_re),
    .o_mem_raddr (mem_raddr)
  );

  // --------------------
  // Write side

  axi_sram_wr_ctrl wr_ctrl0 (
    .i_aclk      (i_aclk),
    .i_rst_n     (i_rst_n),
    .i_awid      (i_awid),
    .i_awaddr    (i_awaddr),
    .i_awlen     (i_awlen),
    .i_awburst   (burst_e'(i_awburst)),
    .i_awvalid   (i_awvalid),
    .o_awready   (o_awready),
    .i_wdata     (i_wdata),
    .i_wstrb     (i_wstrb),
    .i_wlast     (i_wlast),
    .i_wvalid    (i_wvalid),
    .o_wready    (o_wready),
    .o_bid       (o_bid),
    .o_bresp     (o_bresp),
    .o_bvalid    (o_bvalid),
    .i_bready    (i_bready),
    .o_mem_we    (mem_we),
    .o_mem_waddr (mem_waddr),
    .o_mem_wdata (mem_wdata),
    .o_mem_wstrb (mem_wstrb)
  );

  // R data comes directly from the array read register
  sram_mem mem0 (
    .i_aclk  (i_aclk),
    .i_we    (mem_we),
    .i_waddr (mem_waddr),
    .i_wdata (mem_wdata),
    .i_wstrb (mem_wstrb),
    .i_re    (mem_re),
    .i_raddr (mem_raddr),
    .o_rdata (o_rdata)
  );

endmodule

`default_nettype wire

// ==== bench/tb_axi_sram_seq.svh ====
// Bus tasks for AW/W/B and AR/R plus the directed and random test sequence
`ifndef TB_AXI_SRAM_SEQ_SVH
`define TB_AXI_SRAM_SEQ_SVH

// --------------------
// Write side

// wlast goes high on beat wlast_beat only
task automatic write_burst(input logic [ID_WIDTH-1:0] id, input logic [ADDR_WIDTH-1:0] addr,
                           input int len, input burst_e burst, input int wlast_beat,
                           input bit fill);
  logic [ADDR_WIDTH-1:0] a;
  logic [DATA_WIDTH-1:0] data;
  logic [STRB_WIDTH-1:0] strb;
  int                    target;
  exp_bid.push_back(id);
  exp_bresp.push_back(ref_write_resp(addr, len, burst, wlast_beat));
  target = b_count + 1;
  @(negedge i_aclk);
  i_awid    = id;
  i_awaddr  = addr;
  i_awlen   = 8'(len);
  i_awburst = burst;
  i_awvalid = 1'b1;
  while (!o_awready) @(negedge i_aclk);
  @(negedge i_aclk);
  i_awvalid = 1'b0;
  for (int k = 0; k <= len; k++) begin
    a        = beat_addr(addr, burst, k);
    data     = fill ? fill_word(a) : lfsr_take(DATA_WIDTH);
    strb     = fill ? {STRB_WIDTH{1'b1}} : STRB_WIDTH'(lfsr_take(STRB_WIDTH));
    i_wdata  = data;
    i_wstrb  = strb;
    i_wlast  = (k == wlast_beat);
    i_wvalid = 1'b1;
    while (!o_wready) @(negedge i_aclk);
    // Beat lands at the coming edge
    if (in_range(a)) begin
      for (int b = 0; b < STRB_WIDTH; b++) begin
        if (strb[b]) begin
          shadow[word_of(a)][b*8 +: 8] = data[b*8 +: 8];
        end
      end
    end
    @(negedge i_aclk);
  end
  i_wvalid = 1'b0;
  i_wlast  = 1'b0;
  wait (b_count >= target);
endtask

// --------------------
// Read side

task automatic read_burst(input logic [ID_WIDTH-1:0] id, input logic [ADDR_WIDTH-1:0] addr,
                          input int len, input burst_e burst);
  int target;
  for (int k = 0; k <= len; k++) begin
    exp_rdata.push_back(ref_read_beat(addr, burst, k));
    exp_rresp.push_back(in_range(beat_addr(addr, burst, k)) ? RESP_OKAY : RESP_DECERR);
    exp_rid.push_back(id);
    exp_rlast.push_back(k == len);
  end
  target = r_count + len + 1;
  @(negedge i_aclk);
  i_arid    = id;
  i_araddr  = addr;
  i_arlen   = 8'(len);
  i_arburst = burst;
  i_arvalid = 1'b1;
  while (!o_arready) @(negedge i_aclk);
  @(negedge i_aclk);
  i_arvalid = 1'b0;
  wait (r_count >= target);
endtask

// --------------------
// Test sequence

task automatic run_tests();
  logic [ADDR_WIDTH-1:0] waddr;
  logic [ADDR_WIDTH-1:0] raddr;
  logic [ID_WIDTH-1:0]   wr_id;
  logic [ID_WIDTH-1:0]   rd_id;
  int                    wlen;
  int                    rlen;
  // Known contents everywhere first
  for (int i = 0; i < MEM_WORDS / 256; i++) begin
    write_burst(4'h0, ADDR_WIDTH'(i * 256 * STRB_WIDTH), 255, BURST_INCR, 255, 1'b1);
  end
  write_burst(4'h3, 32'h0000_0100, 0, BURST_INCR, 0, 1'b0);
  read_burst(4'h5, 32'h0000_0100, 0, BURST_INCR);
  // Random INCR bursts of 1 to 16 beats
  repeat (8) begin
    waddr = ADDR_WIDTH'(lfsr_take(9)) << BYTE_OFS;
    wlen  = int'(lfsr_take(4));
    write_burst(ID_WIDTH'(lfsr_take(ID_WIDTH)), waddr, wlen, BURST_INCR, wlen, 1'b0);
    read_burst(ID_WIDTH'(lfsr_take(ID_WIDTH)), waddr, wlen, BURST_INCR);
  end
  write_burst(4'h7, 32'h0000_0800, 7, BURST_FIXED, 7, 1'b0);
  read_burst(4'h8, 32'h0000_0800, 5, BURST_FIXED);
  // Beyond the end and across it
  // Words 0 and 1 alias the dropped beats
  write_burst(4'h9, 32'h0000_2000, 0, BURST_INCR, 0, 1'b0);
  write_burst(4'ha, 32'h0000_1ff0, 3, BURST_INCR, 3, 1'b0);
  read_burst(4'hb, 32'h0000_1fe8, 4, BURST_INCR);
  read_burst(4'hc, 32'h0000_0000, 1, BURST_INCR);
  read_burst(4'hd, 32'h0001_0000, 1, BURST_FIXED);
  // Early and late wlast
  write_burst(4'h1, 32'h0000_0400, 5, BURST_INCR, 2, 1'b0);
  write_burst(4'h2, 32'h0000_0500, 3, BURST_INCR, 9, 1'b0);
  read_burst(4'h4, 32'h0000_0400, 5, BURST_INCR);
  read_burst(4'h6, 32'h0000_0500, 3, BURST_INCR);
  // Concurrent traffic with writes below word 144 and reads from word 512 up
  stall_en = 1'b1;
  repeat (6) begin
    waddr = ADDR_WIDTH'(lfsr_take(7)) << BYTE_OFS;
    raddr = (ADDR_WIDTH'(lfsr_take(8)) + 32'd512) << BYTE_OFS;
    wlen  = int'(lfsr_take(4));
    rlen  = int'(lfsr_take(4));
    wr_id = ID_WIDTH'(lfsr_take(ID_WIDTH));
    rd_id = ID_WIDTH'(lfsr_take(ID_WIDTH));
    fork
      write_burst(wr_id, waddr, wlen, BURST_INCR, wlen, 1'b0);
      read_burst(rd_id, raddr, rlen, BURST_INCR);
    join
  end
  stall_en = 1'b0;
endtask

`endif

// ==== bench/tb_axi_sram.sv ====
// Testbench top with clock, reset, DUT, shadow memory, reference model, compare process, watchdog
`timescale 1ns/10ps
`default_nettype none

module tb_axi_sram;

  import axi_sram_pkg::*;

  localparam int CLK_NS        = 20;
  localparam int PLANNED_BEATS = 1600;
  localparam int TIMEOUT_NS    = (PLANNED_BEATS * 40 + 2000) * CLK_NS;

  logic                  i_aclk;
  logic                  i_rst_n;
  logic [ID_WIDTH-1:0]   i_awid;
  logic [ADDR_WIDTH-1:0] i_awaddr;
  logic [7:0]            i_awlen;
  logic [1:0]            i_awburst;
  logic                  i_awvalid;
  logic                  o_awready;
  logic [DATA_WIDTH-1:0] i_wdata;
  logic [STRB_WIDTH-1:0] i_wstrb;
  logic                  i_wlast;
  logic                  i_wvalid;
  logic                  o_wready;
  logic [ID_WIDTH-1:0]   o_bid;
  logic [1:0]            o_bresp;
  logic                  o_bvalid;
  logic                  i_bready;
  logic [ID_WIDTH-1:0]   i_arid;
  logic [ADDR_WIDTH-1:0] i_araddr;
  logic [7:0]            i_arlen;
  logic [1:0]            i_arburst;
  logic                  i_arvalid;
  logic                  o_arready;
  logic [ID_WIDTH-1:0]   o_rid;
  logic [DATA_WIDTH-1:0] o_rdata;
  logic [1:0]            o_rresp;
  logic                  o_rlast;
  logic                  o_rvalid;
  logic                  i_rready;

  // Shadow memory and expected responses in issue order
  logic [DATA_WIDTH-1:0] shadow [MEM_WORDS];
  logic [DATA_WIDTH-1:0] exp_rdata [$];
  resp_e                 exp_rresp [$];
  logic [ID_WIDTH-1:0]   exp_rid [$];
  logic                  exp_rlast [$];
  resp_e                 exp_bresp [$];
  logic [ID_WIDTH-1:0]   exp_bid [$];
  int                    r_count = 0;
  int                    b_count = 0;
  bit                    stall_en = 1'b0;
  logic [31:0]           lfsr_q = 32'ha082;

  axi_sram_top dut0 (.*);

  initial begin
    i_aclk = 1'b0;
    forever #(CLK_NS / 2) i_aclk = ~i_aclk;
  end

  // --------------------
  // Stimulus and reference model

  // Galois LFSR stepped once per bit
  function automatic logic [DATA_WIDTH-1:0] lfsr_take(input int nbits);
    logic [DATA_WIDTH-1:0] val;
    val = '0;
    for (int i = 0; i < nbits; i++) begin
      val    = {val[DATA_WIDTH-2:0], lfsr_q[0]};
      lfsr_q = (lfsr_q >> 1) ^ (lfsr_q[0] ? 32'h8020_0003 : 32'h0);
    end
    return val;
  endfunction

  function automatic logic [ADDR_WIDTH-1:0] beat_addr(input logic [ADDR_WIDTH-1:0] addr,
                                                      input burst_e burst, input int k);
    if (burst == BURST_FIXED) begin
      return addr;
    end
    return addr + ADDR_WIDTH'(k * STRB_WIDTH);
  endfunction

  function automatic bit in_range(input logic [ADDR_WIDTH-1:0] addr);
    return addr < ADDR_WIDTH'(MEM_WORDS * STRB_WIDTH);
  endfunction

  function automatic logic [WORD_AW-1:0] word_of(input logic [ADDR_WIDTH-1:0] addr);
    return WORD_AW'(addr >> BYTE_OFS);
  endfunction

  function automatic logic [DATA_WIDTH-1:0] fill_word(input logic [ADDR_WIDTH-1:0] addr);
    return {addr ^ 32'h5a0f_c3a5, ~addr};
  endfunction

  function automatic logic [DATA_WIDTH-1:0] ref_read_beat(input logic [ADDR_WIDTH-1:0] addr,
                                                          input burst_e burst, input int k);
    return shadow[word_of(beat_addr(addr, burst, k))];
  endfunction

  // DECERR wins over SLVERR
  function automatic resp_e ref_write_resp(input logic [ADDR_WIDTH-1:0] addr, input int len,
                                           input burst_e burst, input int wlast_beat);
    bit oor;
    oor = 1'b0;
    for (int k = 0; k <= len; k++) begin
      if (!in_range(beat_addr(addr, burst, k))) begin
        oor = 1'b1;
      end
    end
    if (oor) begin
      return RESP_DECERR;
    end else if (wlast_beat != len) begin
      return RESP_SLVERR;
    end
    return RESP_OKAY;
  endfunction

  // --------------------
  // Compare tasks

  task automatic report_fail(input string what);
    $display("%s", what);
    $display("Done: errors found");
    $fatal(1, "Run stopped at the first failure");
  endtask

  task automatic check_data(input string name, input logic [DATA_WIDTH-1:0] got,
                            input logic [DATA_WIDTH-1:0] exp);
    if (got !== exp) begin
      report_fail($sformatf("[ERROR] %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_resp(input string name, input resp_e got, input resp_e exp);
    if (got !== exp) begin
      report_fail($sformatf("[ERROR] %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_id(input string name, input logic [ID_WIDTH-1:0] got,
                          input logic [ID_WIDTH-1:0] exp);
    if (got !== exp) begin
      report_fail($sformatf("[ERROR] %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_last(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      report_fail($sformatf("[ERROR] %s got %h expected %h", name, got, exp));
    end
  endtask

  `include "tb_axi_sram_seq.svh"

  // --------------------
  // Ready drive and response compare

  initial begin : response_compare
    logic [DATA_WIDTH-1:0] exp_d;
    resp_e                 exp_r;
    logic [ID_WIDTH-1:0]   exp_i;
    logic                  exp_l;
    logic                  held;
    logic [DATA_WIDTH-1:0] held_data;
    logic [ID_WIDTH-1:0]   held_id;
    resp_e                 held_resp;
    logic                  held_last;
    logic                  held_b;
    logic [ID_WIDTH-1:0]   held_bid;
    resp_e                 held_bresp;
    i_rready   = 1'b0;
    i_bready   = 1'b0;
    held       = 1'b0;
    held_data  = '0;
    held_id    = '0;
    held_resp  = RESP_OKAY;
    held_last  = 1'b0;
    held_b     = 1'b0;
    held_bid   = '0;
    held_bresp = RESP_OKAY;
    @(posedge i_rst_n);
    forever begin
      @(negedge i_aclk);
      // A stalled R beat keeps its payload
      if (held) begin
        if (!o_rvalid) begin
          report_fail("o_rvalid dropped while an R beat was stalled");
        end
        check_data("o_rdata", o_rdata, held_data);
        check_id("o_rid", o_rid, held_id);
        check_resp("o_rresp", resp_e'(o_rresp), held_resp);
        check_last("o_rlast", o_rlast, held_last);
      end
      // Same for a stalled B response
      if (held_b) begin
        if (!o_bvalid) begin
          report_fail("o_bvalid dropped while a B response was stalled");
        end
        check_id("o_bid", o_bid, held_bid);
        check_resp("o_bresp", resp_e'(o_bresp), held_bresp);
      end
      i_rready   = stall_en ? 1'(lfsr_take(1)) : 1'b1;
      i_bready   = stall_en ? 1'(lfsr_take(1)) : 1'b1;
      held       = o_rvalid & ~i_rready;
      held_data  = o_rdata;
      held_id    = o_rid;
      held_resp  = resp_e'(o_rresp);
      held_last  = o_rlast;
      held_b     = o_bvalid & ~i_bready;
      held_bid   = o_bid;
      held_bresp = resp_e'(o_bresp);
      if (o_rvalid && i_rready) begin
        if (exp_rdata.size() == 0) begin
          report_fail("An R beat arrived with no read outstanding");
        end else begin
          exp_d = exp_rdata.pop_front();
          exp_r = exp_rresp.pop_front();
          exp_i = exp_rid.pop_front();
          exp_l = exp_rlast.pop_front();
          check_id("o_rid", o_rid, exp_i);
          check_resp("o_rresp", resp_e'(o_rresp), exp_r);
          check_last("o_rlast", o_rlast, exp_l);
          if (exp_r == RESP_OKAY) begin
            check_data("o_rdata", o_rdata, exp_d);
          end
          r_count++;
        end
      end
      if (o_bvalid && i_bready) begin
        if (exp_bresp.size() == 0) begin
          report_fail("A B response arrived with no write outstanding");
        end else begin
          check_id("o_bid", o_bid, exp_bid.pop_front());
          check_resp("o_bresp", resp_e'(o_bresp), exp_bresp.pop_front());
          b_count++;
        end
      end
    end
  end

  initial begin : watchdog
    #(TIMEOUT_NS);
    report_fail("Timeout: the DUT stopped handshaking before the test sequence finished");
  end

  initial begin : main_sequence
    rd_state_e rd_state;
    i_rst_n   = 1'b0;
    i_awid    = '0;
    i_awaddr  = '0;
    i_awlen   = '0;
    i_awburst = '0;
    i_awvalid = 1'b0;
    i_wdata   = '0;
    i_wstrb   = '0;
    i_wlast   = 1'b0;
    i_wvalid  = 1'b0;
    i_arid    = '0;
    i_araddr  = '0;
    i_arlen   = '0;
    i_arburst = '0;
    i_arvalid = 1'b0;
    repeat (8) @(posedge i_aclk);
    @(negedge i_aclk);
    i_rst_n = 1'b1;
    run_tests();
    rd_state = dut0.rd_ctrl0.state_q;
    $display("Read FSM at end of run: %s", rd_state.name());
    $display("Done: no errors");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+bench
logic/axi_sram_pkg.sv
logic/sram_mem.sv
logic/axi_sram_rd_ctrl.sv
logic/axi_sram_wr_ctrl.sv
logic/axi_sram_top.sv
bench/tb_axi_sram.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the AXI4 SRAM testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_axi_sram -f tb.f -o sim_axi_sram

# A fatal stop still leaves its output for the search below
out="$(./obj_dir/sim_axi_sram || true)"
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "Done: no errors"; then
  exit 0
fi
exit 1
